//--- sd_pkg.sv
package sd_pkg;

    // one grid cell where 0 is blank and 1 to 9 are digits
    typedef logic [3:0] cell_t;

    // row or column index from 0 to 8
    typedef logic [3:0] coord_t;

    // grid geometry
    localparam int GRID_DIM = 9;
    localparam int BOX_DIM  = 3;

    // highest legal digit
    localparam cell_t DIGIT_MAX = 4'd9;

    // value stored in an empty cell
    localparam cell_t CELL_BLANK = 4'd0;

    // reported once when no solution exists
    localparam cell_t CODE_FAIL = 4'd10;

endpackage

//--- sd_grid.sv
`timescale 1ns/1ps

module sd_grid (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           load_en,
    input  sd_pkg::cell_t  load_data,
    input  sd_pkg::coord_t load_row,
    input  sd_pkg::coord_t load_col,
    input  sd_pkg::coord_t cur_row,
    input  sd_pkg::coord_t cur_col,
    input  sd_pkg::coord_t prev_row,
    input  sd_pkg::coord_t prev_col,
    input  sd_pkg::cell_t  digit,
    input  logic           write_en,
    input  logic           clear_en,
    output logic           conflict,
    output sd_pkg::cell_t  cur_value,
    output sd_pkg::cell_t  prev_value
);
    import sd_pkg::*;

    cell_t  cells [GRID_DIM][GRID_DIM];
    coord_t box_row;
    coord_t box_col;
    logic   hit_row;
    logic   hit_col;
    logic   hit_box;

    // load, solve and back-off never overlap
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < GRID_DIM; r++)
            begin
                for (int c = 0; c < GRID_DIM; c++)
                begin
                    cells[r][c] <= CELL_BLANK;
                end
            end
        end
        else if (load_en)
        begin
            cells[load_row][load_col] <= load_data;
        end
        else if (write_en)
        begin
            cells[cur_row][cur_col] <= digit;
        end
        else if (clear_en)
        begin
            cells[prev_row][prev_col] <= CELL_BLANK;
        end
    end

    // top-left corner of the box holding the current blank
    assign box_row = coord_t'((cur_row / BOX_DIM) * BOX_DIM);
    assign box_col = coord_t'((cur_col / BOX_DIM) * BOX_DIM);

    always_comb
    begin
        hit_row = 1'b0;
        hit_col = 1'b0;
        for (int i = 0; i < GRID_DIM; i++)
        begin
            if (cells[cur_row][i] == digit)
                hit_row = 1'b1;
            if (cells[i][cur_col] == digit)
                hit_col = 1'b1;
        end
    end

    always_comb
    begin
        hit_box = 1'b0;
        for (int r = 0; r < BOX_DIM; r++)
        begin
            for (int c = 0; c < BOX_DIM; c++)
            begin
                if (cells[box_row + r][box_col + c] == digit)
                    hit_box = 1'b1;
            end
        end
    end

    // the blank itself holds 0 and cannot match a candidate
    assign conflict = hit_row | hit_col | hit_box;

    assign cur_value  = cells[cur_row][cur_col];
    assign prev_value = cells[prev_row][prev_col];

endmodule

//--- sd_blank_list.sv
`timescale 1ns/1ps

module sd_blank_list #(
    parameter  int n_blanks = 15,
    localparam int cur_w    = (n_blanks > 1) ? $clog2(n_blanks) : 1,
    localparam int cnt_w    = $clog2(n_blanks + 1)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load_en,
    input  logic             restart,
    input  sd_pkg::cell_t    load_data,
    input  logic [cur_w-1:0] cursor,
    output sd_pkg::coord_t   load_row,
    output sd_pkg::coord_t   load_col,
    output logic             load_last,
    output sd_pkg::coord_t   cur_row,
    output sd_pkg::coord_t   cur_col,
    output sd_pkg::coord_t   prev_row,
    output sd_pkg::coord_t   prev_col
);
    import sd_pkg::*;

    coord_t           tab_row [n_blanks];
    coord_t           tab_col [n_blanks];
    logic [cnt_w-1:0] fill;
    logic [cur_w-1:0] prev_idx;
    logic             blank_in;

    assign blank_in  = load_en && (load_data == CELL_BLANK);
    assign load_last = (load_row == coord_t'(GRID_DIM - 1))
                    && (load_col == coord_t'(GRID_DIM - 1));

    // row-major load position
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            load_row <= '0;
            load_col <= '0;
        end
        else if (restart)
        begin
            load_row <= '0;
            load_col <= '0;
        end
        else if (load_en)
        begin
            if (load_col == coord_t'(GRID_DIM - 1))
            begin
                load_col <= '0;
                load_row <= load_last ? '0 : load_row + 1'b1;
            end
            else
                load_col <= load_col + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            fill <= '0;
        else if (restart)
            fill <= '0;
        else if (blank_in)
            fill <= fill + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (blank_in)
        begin
            tab_row[fill] <= load_row;
            tab_col[fill] <= load_col;
        end
    end

    // entry 0 has no predecessor so its index stays 0
    assign prev_idx = (cursor == '0) ? '0 : cursor - 1'b1;

    assign cur_row  = tab_row[cursor];
    assign cur_col  = tab_col[cursor];
    assign prev_row = tab_row[prev_idx];
    assign prev_col = tab_col[prev_idx];

endmodule

//--- sd_ctrl.sv
`timescale 1ns/1ps

module sd_ctrl #(
    parameter  int n_blanks = 15,
    localparam int cur_w    = (n_blanks > 1) ? $clog2(n_blanks) : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic             load_last,
    input  logic             conflict,
    input  sd_pkg::cell_t    cur_value,
    input  sd_pkg::cell_t    prev_value,
    output logic             load_en,
    output logic             restart,
    output logic             write_en,
    output logic             clear_en,
    output logic [cur_w-1:0] cursor,
    output sd_pkg::cell_t    digit,
    output logic             out_valid,
    output sd_pkg::cell_t    out
);
    import sd_pkg::*;

    localparam logic [1:0] ST_LOAD   = 2'd0;
    localparam logic [1:0] ST_SOLVE  = 2'd1;
    localparam logic [1:0] ST_REPORT = 2'd2;
    localparam logic [1:0] ST_FAIL   = 2'd3;

    localparam logic [cur_w-1:0] CUR_LAST = cur_w'(n_blanks - 1);

    logic [1:0] state;
    logic [1:0] state_next;
    logic       accept;
    logic       step;
    logic       back;
    logic       at_first;
    logic       at_last;

    assign at_first = (cursor == '0);
    assign at_last  = (cursor == CUR_LAST);

    // one of accept, step, back per solve cycle
    assign accept = (state == ST_SOLVE) && (digit <= DIGIT_MAX) && !conflict;
    assign step   = (state == ST_SOLVE) && conflict && (digit < DIGIT_MAX);
    assign back   = (state == ST_SOLVE) && !accept && !step;

    assign load_en  = in_valid && (state == ST_LOAD);
    assign write_en = accept;
    assign clear_en = back && !at_first;
    assign restart  = ((state == ST_REPORT) && at_last) || (state == ST_FAIL);

    always_comb
    begin
        state_next = state;
        case (state)
            ST_LOAD:
                if (load_en && load_last)
                    state_next = ST_SOLVE;
            ST_SOLVE:
                if (accept && at_last)
                    state_next = ST_REPORT;
                else if (back && at_first)
                    state_next = ST_FAIL;
            ST_REPORT:
                if (at_last)
                    state_next = ST_LOAD;
            default:
                state_next = ST_LOAD;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_LOAD;
        else
            state <= state_next;
    end

    // blank cursor and candidate digit
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cursor <= '0;
            digit  <= 4'd1;
        end
        else
        begin
            case (state)
                ST_SOLVE:
                    if (accept)
                    begin
                        cursor <= at_last ? '0 : cursor + 1'b1;
                        digit  <= 4'd1;
                    end
                    else if (step)
                        digit <= digit + 4'd1;
                    else
                    begin
                        // resume the previous blank past its last value
                        cursor <= at_first ? '0 : cursor - 1'b1;
                        digit  <= prev_value + 4'd1;
                    end
                ST_REPORT:
                    cursor <= at_last ? '0 : cursor + 1'b1;
                default:
                begin
                    cursor <= '0;
                    digit  <= 4'd1;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            out       <= '0;
        end
        else if (state == ST_REPORT)
        begin
            out_valid <= 1'b1;
            out       <= cur_value;
        end
        else if (state == ST_FAIL)
        begin
            out_valid <= 1'b1;
            out       <= CODE_FAIL;
        end
        else
        begin
            out_valid <= 1'b0;
            out       <= '0;
        end
    end

endmodule

//--- sd_top.sv
`timescale 1ns/1ps

module sd_top #(
    parameter int n_blanks = 15
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  sd_pkg::cell_t in,
    output logic          out_valid,
    output sd_pkg::cell_t out
);
    import sd_pkg::*;

    localparam int cur_w = (n_blanks > 1) ? $clog2(n_blanks) : 1;

    logic             load_en;
    logic             restart;
    logic             write_en;
    logic             clear_en;
    logic             load_last;
    logic             conflict;
    logic [cur_w-1:0] cursor;
    cell_t            digit;
    cell_t            cur_value;
    cell_t            prev_value;
    coord_t           load_row;
    coord_t           load_col;
    coord_t           cur_row;
    coord_t           cur_col;
    coord_t           prev_row;
    coord_t           prev_col;

    sd_grid i_sd_grid (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_en    (load_en),
        .load_data  (in),
        .load_row   (load_row),
        .load_col   (load_col),
        .cur_row    (cur_row),
        .cur_col    (cur_col),
        .prev_row   (prev_row),
        .prev_col   (prev_col),
        .digit      (digit),
        .write_en   (write_en),
        .clear_en   (clear_en),
        .conflict   (conflict),
        .cur_value  (cur_value),
        .prev_value (prev_value)
    );

    sd_blank_list #(
        .n_blanks (n_blanks)
    ) i_sd_blank_list (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .restart   (restart),
        .load_data (in),
        .cursor    (cursor),
        .load_row  (load_row),
        .load_col  (load_col),
        .load_last (load_last),
        .cur_row   (cur_row),
        .cur_col   (cur_col),
        .prev_row  (prev_row),
        .prev_col  (prev_col)
    );

    sd_ctrl #(
        .n_blanks (n_blanks)
    ) i_sd_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .load_last  (load_last),
        .conflict   (conflict),
        .cur_value  (cur_value),
        .prev_value (prev_value),
        .load_en    (load_en),
        .restart    (restart),
        .write_en   (write_en),
        .clear_en   (clear_en),
        .cursor     (cursor),
        .digit      (digit),
        .out_valid  (out_valid),
        .out        (out)
    );

endmodule

//--- tb_sd_checker.sv
`timescale 1ns/1ps

module tb_sd_checker #(
    parameter int n_blanks   = 15,
    parameter int max_cycles = 100000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  out_valid,
    input  sd_pkg::cell_t         out,
    input  logic                  armed,
    input  logic [4*n_blanks-1:0] exp_digits,
    input  logic                  exp_fail,
    output int                    results,
    output int                    errors,
    output logic                  timed_out
);
    import sd_pkg::*;

    int    idx;
    int    cycles;
    logic  finished;
    cell_t want;

    task automatic compare_out(input cell_t exp_value, input int pos);
        if (out !== exp_value)
        begin
            errors++;
            $display("MISMATCH out (digit %0d): expected 0x%h, got 0x%h", pos, exp_value, out);
        end
    endtask

    // DUT outputs are registered, so values seen here are the pre-edge ones
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            results   = 0;
            errors    = 0;
            cycles    = 0;
            idx       = 0;
            finished  = 1'b0;
            timed_out = 1'b0;
        end
        else
        begin
            cycles = cycles + 1;
            if (cycles == max_cycles)
            begin
                timed_out = 1'b1;
                $display("timeout: no result from the solver after %0d cycles", cycles);
            end
            if (!armed)
                finished = 1'b0;
            if (!out_valid && out !== 4'h0)
            begin
                errors++;
                $display("MISMATCH out (out_valid low): expected 0x0, got 0x%h", out);
            end
            if (out_valid)
            begin
                // a frame is open only once the whole puzzle is in
                if (!armed || finished)
                begin
                    errors++;
                    $display("out_valid was high outside an expected result frame");
                end
                else if (exp_fail)
                begin
                    compare_out(CODE_FAIL, 0);
                    results++;
                    finished = 1'b1;
                end
                else
                begin
                    want = exp_digits[4*(n_blanks-1-idx) +: 4];
                    compare_out(want, idx);
                    idx++;
                    if (idx == n_blanks)
                    begin
                        results++;
                        finished = 1'b1;
                        idx      = 0;
                    end
                end
            end
            else if (idx != 0)
            begin
                errors++;
                $display("out_valid dropped after %0d of %0d digits", idx, n_blanks);
                idx      = 0;
                results++;
                finished = 1'b1;
            end
        end
    end

endmodule

//--- tb_sd.sv
`timescale 1ns/1ps

module tb_sd;
    import sd_pkg::*;

    localparam int n_blanks   = 15;
    localparam int n_puzzles  = 5;
    localparam int max_cycles = n_puzzles * 100000;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    cell_t                 in;
    logic                  out_valid;
    cell_t                 out;
    logic                  armed;
    logic [4*n_blanks-1:0] exp_digits;
    logic                  exp_fail;
    int                    results;
    int                    errors;
    logic                  timed_out;
    logic [31:0]           rng;

    // 81 cells row-major with cell 0 in the top nibble
    logic [323:0]          puzzle [n_puzzles];
    logic [4*n_blanks-1:0] solution [n_puzzles];
    logic                  unsolvable [n_puzzles];
    logic                  gaps [n_puzzles];

    sd_top #(
        .n_blanks (n_blanks)
    ) i_sd_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in        (in),
        .out_valid (out_valid),
        .out       (out)
    );

    tb_sd_checker #(
        .n_blanks   (n_blanks),
        .max_cycles (max_cycles)
    ) i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_valid  (out_valid),
        .out        (out),
        .armed      (armed),
        .exp_digits (exp_digits),
        .exp_fail   (exp_fail),
        .results    (results),
        .errors     (errors),
        .timed_out  (timed_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic build_table();
        // unique by elimination since every blank is forced by its row or column
        puzzle[0]     = {180'h023406780_450789023_709120456_234067801_067891234,
                         144'h891204567_345678910_670912345_902345078};
        solution[0]   = 60'h159618359532816;
        unsolvable[0] = 1'b0;
        gaps[0]       = 1'b0;
        // empty top-left box plus its row and column where the smallest candidates are wrong
        puzzle[1]     = {180'h000054021_000321987_000987654_076543219_543209876,
                         144'h219876543_065432198_432198765_198765430};
        solution[1]   = 60'h987636543218172;
        unsolvable[1] = 1'b0;
        gaps[1]       = 1'b0;
        puzzle[2]     = puzzle[0];
        solution[2]   = solution[0];
        unsolvable[2] = 1'b0;
        gaps[2]       = 1'b1;
        // a 1 at row 2 col 7 leaves the blank at row 1 col 6 without a digit
        puzzle[3]     = {180'h023406780_450789023_709120416_234067801_067891234,
                         144'h891204567_345678910_670912345_902345078};
        solution[3]   = '0;
        unsolvable[3] = 1'b1;
        gaps[3]       = 1'b0;
        puzzle[4]     = puzzle[1];
        solution[4]   = solution[1];
        unsolvable[4] = 1'b0;
        gaps[4]       = 1'b1;
    endtask

    task automatic load_puzzle(input logic [323:0] grid, input logic use_gaps);
        int idle;
        for (int k = 0; k < 81; k++)
        begin
            idle = 0;
            if (use_gaps)
            begin
                rng  = next_rand(rng);
                idle = (rng[1:0] == 2'd0) ? int'(rng[4:2]) + 1 : 0;
            end
            in_valid = 1'b0;
            in       = '0;
            repeat (idle)
            begin
                @(posedge clk);
                #2;
            end
            in_valid = 1'b1;
            in       = grid[323 - 4*k -: 4];
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
        in       = '0;
    endtask

    initial
    begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in         = '0;
        armed      = 1'b0;
        exp_digits = '0;
        exp_fail   = 1'b0;
        rng        = 32'd77273;
        build_table();
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // idle stretch where any output is flagged
        repeat (20) @(posedge clk);
        #2;
        for (int i = 0; i < n_puzzles; i++)
        begin
            armed      = 1'b0;
            exp_digits = solution[i];
            exp_fail   = unsolvable[i];
            load_puzzle(puzzle[i], gaps[i]);
            armed = 1'b1;
            wait (results > i || timed_out);
            if (timed_out)
                break;
            @(posedge clk);
            #2;
        end
        // catch stray outputs after the last frame
        repeat (20) @(posedge clk);
        $display("errors: %0d, results: %0d of %0d", errors, results, n_puzzles);
        if (errors == 0 && !timed_out && results == n_puzzles)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb.f
sd_pkg.sv
sd_grid.sv
sd_blank_list.sv
sd_ctrl.sv
sd_top.sv
tb_sd_checker.sv
tb_sd.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_sd -o tb_sd_sim
./obj_dir/tb_sd_sim > sim.log 2>&1
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
